//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_cnn_ctrl
FILELIST := verilog.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) hdl/cnn_defines.svh

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- hdl/cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "cnn_defines.svh"

module cmd_fifo (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_valid,
    input  wire cmd_pkg::cmd_word_t i_word,
    output logic                    o_ready,
    output logic                    o_valid,
    output cmd_pkg::cmd_word_t      o_word,
    input  wire                     i_ready
);
    localparam int DEPTH = `CMD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cmd_pkg::cmd_word_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    // Full and empty straight from the occupancy count
    assign o_ready = (count != CNT_W'(DEPTH));
    assign o_valid = (count != '0);
    // Head word shows as soon as the count is nonzero
    assign o_word  = mem[rd_ptr];

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the last entry
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Full means the write side has come round to the read side
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        !o_ready |-> (wr_ptr == rd_ptr));

    // Empty means the read side has caught up with the write side
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        !o_valid |-> (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

//--- hdl/cmd_pkg.sv
`default_nettype none
`include "cnn_defines.svh"

package cmd_pkg;

    // Raw word as pushed by the host
    typedef logic [31:0] cmd_word_t;

    // Layer operation codes that the engine accepts
    typedef enum logic [2:0] {
        OP_IDLE      = 3'b000,
        OP_CONV_RELU = 3'b001,
        OP_MAX_POOL  = 3'b100,
        OP_AVG_POOL  = 3'b101
    } op_type_t;

    // Descriptor field widths
    typedef logic [3:0]  stride_t;
    typedef logic [7:0]  kernel_t;
    typedef logic [15:0] chan_t;
    typedef logic [7:0]  side_t;

    // SDRAM word address
    typedef logic [31:0] addr_t;

    // Commands per run
    typedef logic [`CMD_CNT_W-1:0] cmd_cnt_t;

endpackage

`default_nettype wire

//--- hdl/cmd_sequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "cnn_defines.svh"

module cmd_sequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_op_en,
    input  wire cmd_pkg::cmd_cnt_t  i_cmd_count,
    input  wire                     i_fifo_valid,
    input  wire cmd_pkg::cmd_word_t i_fifo_word,
    input  wire                     i_eng_ready,
    input  wire                     i_eng_done,
    output logic                    o_fifo_ready,
    output logic                    o_eng_valid,
    output cmd_pkg::op_type_t       o_op_type,
    output logic                    o_padding,
    output cmd_pkg::stride_t        o_stride,
    output cmd_pkg::kernel_t        o_kernel,
    output cmd_pkg::chan_t          o_i_channel,
    output cmd_pkg::chan_t          o_o_channel,
    output cmd_pkg::side_t          o_i_side,
    output cmd_pkg::side_t          o_o_side,
    output cmd_pkg::addr_t          o_weight_addr,
    output cmd_pkg::addr_t          o_data_addr,
    output cmd_pkg::addr_t          o_result_addr,
    output logic                    o_busy,
    output logic                    o_irq
);
    localparam int WCNT_W = $clog2(`CMD_WORDS);

    ctrl_pkg::seq_state_t state;
    ctrl_pkg::seq_state_t state_nxt;
    logic [WCNT_W-1:0]    word_cnt;
    cmd_pkg::cmd_cnt_t    done_cnt;
    cmd_pkg::cmd_cnt_t    done_cnt_inc;
    logic                 pop;
    logic                 last_word;
    logic                 eng_accept;

    // FIFO is only drained while collecting a command
    assign o_fifo_ready = (state == ctrl_pkg::SEQ_FETCH);
    assign pop          = o_fifo_ready && i_fifo_valid;
    assign last_word    = (word_cnt == WCNT_W'(`CMD_WORDS - 1));
    assign eng_accept   = o_eng_valid && i_eng_ready;
    assign done_cnt_inc = done_cnt + 1'b1;

    // Status flags decoded from state
    assign o_busy = (state != ctrl_pkg::SEQ_IDLE) && (state != ctrl_pkg::SEQ_FINISH);
    assign o_irq  = (state == ctrl_pkg::SEQ_FINISH);

    always_comb begin
        state_nxt = state;
        case (state)
            ctrl_pkg::SEQ_IDLE: begin
                // An empty run finishes at once
                if (i_op_en) begin
                    state_nxt = (i_cmd_count == '0) ? ctrl_pkg::SEQ_FINISH : ctrl_pkg::SEQ_FETCH;
                end
            end
            ctrl_pkg::SEQ_FETCH: begin
                if (pop && last_word) begin
                    state_nxt = ctrl_pkg::SEQ_ISSUE;
                end
            end
            ctrl_pkg::SEQ_ISSUE: begin
                state_nxt = ctrl_pkg::SEQ_RUN;
            end
            ctrl_pkg::SEQ_RUN: begin
                // Next command or end of run
                if (i_eng_done) begin
                    state_nxt = (done_cnt_inc == i_cmd_count) ? ctrl_pkg::SEQ_FINISH
                                                               : ctrl_pkg::SEQ_FETCH;
                end
            end
            ctrl_pkg::SEQ_FINISH: begin
                // Interrupt held until the host drops the enable
                if (!i_op_en) begin
                    state_nxt = ctrl_pkg::SEQ_IDLE;
                end
            end
            default: state_nxt = ctrl_pkg::SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ctrl_pkg::SEQ_IDLE;
            word_cnt    <= '0;
            done_cnt    <= '0;
            o_eng_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            // Completion count restarts with every run
            if (state == ctrl_pkg::SEQ_IDLE) begin
                done_cnt <= '0;
            end else if (state == ctrl_pkg::SEQ_RUN && i_eng_done) begin
                done_cnt <= done_cnt_inc;
            end
            // Word index wraps after the sixth word
            if (pop) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
            // Valid rises the cycle after issue and drops on acceptance
            if (state == ctrl_pkg::SEQ_ISSUE) begin
                o_eng_valid <= 1'b1;
            end else if (eng_accept) begin
                o_eng_valid <= 1'b0;
            end
        end
    end

    // Split each popped word into its descriptor fields
    always_ff @(posedge clk) begin
        if (pop) begin
            case (word_cnt)
                0: begin
                    o_op_type <= cmd_pkg::op_type_t'(i_fifo_word[2:0]);
                    o_padding <= i_fifo_word[4];
                    o_stride  <= i_fifo_word[11:8];
                    o_kernel  <= i_fifo_word[23:16];
                end
                1: begin
                    o_i_channel <= i_fifo_word[15:0];
                    o_o_channel <= i_fifo_word[31:16];
                end
                2: begin
                    o_i_side <= i_fifo_word[7:0];
                    o_o_side <= i_fifo_word[15:8];
                end
                3: o_weight_addr <= i_fifo_word;
                4: o_data_addr   <= i_fifo_word;
                5: o_result_addr <= i_fifo_word;
                default: ;
            endcase
        end
    end

    // Descriptor stays offered and unchanged until the engine takes it
    a_eng_valid_hold: assert property (@(posedge clk) disable iff (rst)
        (o_eng_valid && !i_eng_ready) |=> (o_eng_valid && $stable(o_result_addr)));

    // Engine completion only arrives while a command is running
    a_done_in_run: assert property (@(posedge clk) disable iff (rst)
        i_eng_done |-> (state == ctrl_pkg::SEQ_RUN && !o_eng_valid));

endmodule

`default_nettype wire

//--- hdl/cnn_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_ctrl_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_op_en,
    input  wire cmd_pkg::cmd_cnt_t  i_cmd_count,
    input  wire                     i_cmd_valid,
    input  wire cmd_pkg::cmd_word_t i_cmd_word,
    output logic                    o_cmd_ready,
    output cmd_pkg::op_type_t       o_op_type,
    output logic                    o_padding,
    output cmd_pkg::stride_t        o_stride,
    output cmd_pkg::kernel_t        o_kernel,
    output cmd_pkg::chan_t          o_i_channel,
    output cmd_pkg::chan_t          o_o_channel,
    output cmd_pkg::side_t          o_i_side,
    output cmd_pkg::side_t          o_o_side,
    output cmd_pkg::addr_t          o_weight_addr,
    output cmd_pkg::addr_t          o_data_addr,
    output cmd_pkg::addr_t          o_result_addr,
    output logic                    o_wb_valid,
    output cmd_pkg::addr_t          o_wb_addr,
    input  wire                     i_wb_ready,
    output logic                    o_busy,
    output logic                    o_irq,
    output logic                    o_err
);
    // FIFO to sequencer
    logic               fifo_valid;
    logic               fifo_ready;
    cmd_pkg::cmd_word_t fifo_word;
    // Sequencer to engine handshake and completion
    logic               eng_valid;
    logic               eng_ready;
    logic               eng_done;

    cmd_fifo u_cmd_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_cmd_valid),
        .i_word  (i_cmd_word),
        .o_ready (o_cmd_ready),
        .o_valid (fifo_valid),
        .o_word  (fifo_word),
        .i_ready (fifo_ready)
    );

    // Descriptor fields feed both the top ports and the engine
    cmd_sequencer u_cmd_sequencer (
        .clk           (clk),
        .rst           (rst),
        .i_op_en       (i_op_en),
        .i_cmd_count   (i_cmd_count),
        .i_fifo_valid  (fifo_valid),
        .i_fifo_word   (fifo_word),
        .i_eng_ready   (eng_ready),
        .i_eng_done    (eng_done),
        .o_fifo_ready  (fifo_ready),
        .o_eng_valid   (eng_valid),
        .o_op_type     (o_op_type),
        .o_padding     (o_padding),
        .o_stride      (o_stride),
        .o_kernel      (o_kernel),
        .o_i_channel   (o_i_channel),
        .o_o_channel   (o_o_channel),
        .o_i_side      (o_i_side),
        .o_o_side      (o_o_side),
        .o_weight_addr (o_weight_addr),
        .o_data_addr   (o_data_addr),
        .o_result_addr (o_result_addr),
        .o_busy        (o_busy),
        .o_irq         (o_irq)
    );

    wb_addr_engine u_wb_addr_engine (
        .clk           (clk),
        .rst           (rst),
        .i_valid       (eng_valid),
        .o_ready       (eng_ready),
        .i_op_type     (o_op_type),
        .i_o_channel   (o_o_channel),
        .i_o_side      (o_o_side),
        .i_result_addr (o_result_addr),
        .o_done        (eng_done),
        .o_err         (o_err),
        .o_wb_valid    (o_wb_valid),
        .o_wb_addr     (o_wb_addr),
        .i_wb_ready    (i_wb_ready)
    );

endmodule

`default_nettype wire

//--- hdl/cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// Command format
// One layer descriptor is six 32-bit words
`define CMD_WORDS 6

// Host command FIFO
// Entry count, the FIFO derives its pointer width from it
`define CMD_FIFO_DEPTH 8

// Run control
// Width of the per-run command count allows up to 127 commands
`define CMD_CNT_W 7

`endif

//--- hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // Command sequencer states
    typedef enum logic [2:0] {SEQ_IDLE, SEQ_FETCH, SEQ_ISSUE, SEQ_RUN, SEQ_FINISH} seq_state_t;

    // Write-back address engine states
    typedef enum logic [1:0] {WB_IDLE, WB_STREAM, WB_DONE} wb_state_t;

endpackage

`default_nettype wire

//--- hdl/wb_addr_engine.sv
`timescale 1ns/100ps
`default_nettype none

module wb_addr_engine (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_valid,
    output logic                   o_ready,
    input  wire cmd_pkg::op_type_t i_op_type,
    input  wire cmd_pkg::chan_t    i_o_channel,
    input  wire cmd_pkg::side_t    i_o_side,
    input  wire cmd_pkg::addr_t    i_result_addr,
    output logic                   o_done,
    output logic                   o_err,
    output logic                   o_wb_valid,
    output cmd_pkg::addr_t         o_wb_addr,
    input  wire                    i_wb_ready
);
    // Wide enough for channels times side squared
    localparam int ELEM_W = $bits(cmd_pkg::chan_t) + 2 * $bits(cmd_pkg::side_t);

    ctrl_pkg::wb_state_t state;
    ctrl_pkg::wb_state_t state_nxt;
    logic [ELEM_W-1:0]   elem_total;
    logic [ELEM_W-1:0]   elem_count;
    logic [ELEM_W-1:0]   remaining;
    logic                op_bad;
    logic                accept;
    logic                xfer;
    logic                last_xfer;

    assign o_ready    = (state == ctrl_pkg::WB_IDLE);
    assign o_wb_valid = (state == ctrl_pkg::WB_STREAM);
    // One-cycle completion pulse
    assign o_done     = (state == ctrl_pkg::WB_DONE);

    assign accept    = i_valid && o_ready;
    assign xfer      = o_wb_valid && i_wb_ready;
    assign last_xfer = xfer && (remaining == ELEM_W'(1));

    // Output elements of one layer
    assign elem_total = ELEM_W'(i_o_channel) * ELEM_W'(i_o_side) * ELEM_W'(i_o_side);

    // Idle and unknown ops stream nothing and unknown ones are flagged
    always_comb begin
        elem_count = '0;
        op_bad     = 1'b0;
        case (i_op_type)
            cmd_pkg::OP_IDLE:      elem_count = '0;
            cmd_pkg::OP_CONV_RELU: elem_count = elem_total;
            cmd_pkg::OP_MAX_POOL:  elem_count = elem_total;
            cmd_pkg::OP_AVG_POOL:  elem_count = elem_total;
            default:               op_bad = 1'b1;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ctrl_pkg::WB_IDLE: begin
                if (accept) begin
                    state_nxt = (elem_count == '0) ? ctrl_pkg::WB_DONE : ctrl_pkg::WB_STREAM;
                end
            end
            ctrl_pkg::WB_STREAM: begin
                if (last_xfer) begin
                    state_nxt = ctrl_pkg::WB_DONE;
                end
            end
            ctrl_pkg::WB_DONE: state_nxt = ctrl_pkg::WB_IDLE;
            default:           state_nxt = ctrl_pkg::WB_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ctrl_pkg::WB_IDLE;
            o_err <= 1'b0;
        end else begin
            state <= state_nxt;
            // Sticky until reset
            if (accept && op_bad) begin
                o_err <= 1'b1;
            end
        end
    end

    // Address walks up from the base by one step per taken address
    always_ff @(posedge clk) begin
        if (accept) begin
            remaining <= elem_count;
            o_wb_addr <= i_result_addr;
        end else if (xfer) begin
            remaining <= remaining - 1'b1;
            o_wb_addr <= o_wb_addr + 1'b1;
        end
    end

    // Stalled address is neither dropped nor changed
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (o_wb_valid && !i_wb_ready) |=> (o_wb_valid && $stable(o_wb_addr)));

endmodule

`default_nettype wire

//--- testbench/tb_cnn_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cnn_ctrl;
    localparam int NUM_CMDS        = 7;
    localparam int PUSH_LIMIT      = 200;
    localparam int RUN_LIMIT       = 3000;
    localparam int IRQ_CLEAR_LIMIT = 10;

    logic               clk;
    logic               rst;
    logic               i_op_en;
    cmd_pkg::cmd_cnt_t  i_cmd_count;
    logic               i_cmd_valid;
    cmd_pkg::cmd_word_t i_cmd_word;
    logic               o_cmd_ready;
    cmd_pkg::op_type_t  o_op_type;
    logic               o_padding;
    cmd_pkg::stride_t   o_stride;
    cmd_pkg::kernel_t   o_kernel;
    cmd_pkg::chan_t     o_i_channel;
    cmd_pkg::chan_t     o_o_channel;
    cmd_pkg::side_t     o_i_side;
    cmd_pkg::side_t     o_o_side;
    cmd_pkg::addr_t     o_weight_addr;
    cmd_pkg::addr_t     o_data_addr;
    cmd_pkg::addr_t     o_result_addr;
    logic               o_wb_valid;
    cmd_pkg::addr_t     o_wb_addr;
    logic               i_wb_ready;
    logic               o_busy;
    logic               o_irq;
    logic               o_err;

    // Command table with op type, output channels, output side, result base and error flag
    // Entries 0..3 form the first run (supported ops only), 4..6 the second
    logic [2:0]     tbl_op     [NUM_CMDS] = '{3'b001, 3'b100, 3'b101, 3'b001,
                                              3'b000, 3'b010, 3'b101};
    cmd_pkg::chan_t tbl_ochan  [NUM_CMDS] = '{16'd4, 16'd2, 16'd1, 16'd3, 16'd5, 16'd2, 16'd2};
    cmd_pkg::side_t tbl_oside  [NUM_CMDS] = '{8'd3, 8'd2, 8'd5, 8'd1, 8'd4, 8'd2, 8'd3};
    cmd_pkg::addr_t tbl_result [NUM_CMDS] = '{32'h0000_4000, 32'h0000_5000, 32'h0000_6000,
                                              32'h0000_7000, 32'h0000_8000, 32'h0000_9000,
                                              32'h0000_a000};
    logic           tbl_err    [NUM_CMDS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    int             errors;
    int             timeouts;
    bit             timed_out;
    bit             saw_full;
    logic           sticky_err;
    int             issue_idx;
    int             run_end;
    int             run_issued;
    // Reference stream of write-back addresses still owed by the DUT
    cmd_pkg::addr_t exp_addr [$];

    cnn_ctrl_top u_cnn_ctrl_top (
        .clk           (clk),
        .rst           (rst),
        .i_op_en       (i_op_en),
        .i_cmd_count   (i_cmd_count),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd_word    (i_cmd_word),
        .o_cmd_ready   (o_cmd_ready),
        .o_op_type     (o_op_type),
        .o_padding     (o_padding),
        .o_stride      (o_stride),
        .o_kernel      (o_kernel),
        .o_i_channel   (o_i_channel),
        .o_o_channel   (o_o_channel),
        .o_i_side      (o_i_side),
        .o_o_side      (o_o_side),
        .o_weight_addr (o_weight_addr),
        .o_data_addr   (o_data_addr),
        .o_result_addr (o_result_addr),
        .o_wb_valid    (o_wb_valid),
        .o_wb_addr     (o_wb_addr),
        .i_wb_ready    (i_wb_ready),
        .o_busy        (o_busy),
        .o_irq         (o_irq),
        .o_err         (o_err)
    );

    always #10 clk = ~clk;

    // Fields not held in the table follow from the entry index
    function automatic logic pad_of(input int idx);
        return idx[0];
    endfunction

    function automatic cmd_pkg::stride_t stride_of(input int idx);
        return 4'(idx + 1);
    endfunction

    function automatic cmd_pkg::kernel_t kernel_of(input int idx);
        return 8'(2 * idx + 1);
    endfunction

    function automatic cmd_pkg::chan_t ichan_of(input int idx);
        return 16'(idx + 48);
    endfunction

    function automatic cmd_pkg::side_t iside_of(input int idx);
        return 8'(idx + 8);
    endfunction

    // Command word layout with filler in the unused bits
    function automatic cmd_pkg::cmd_word_t cmd_word(input int idx, input int w);
        case (w)
            0: return {8'ha5, kernel_of(idx), 4'h6, stride_of(idx), 3'b010, pad_of(idx),
                       1'b0, tbl_op[idx]};
            1: return {tbl_ochan[idx], ichan_of(idx)};
            2: return {16'hbeef, tbl_oside[idx], iside_of(idx)};
            3: return 32'h1000_0000 + 32'(idx) * 32'h100;
            4: return 32'h2000_0000 + 32'(idx) * 32'h100;
            default: return tbl_result[idx];
        endcase
    endfunction

    // Only conv and the two pooling ops write results
    function automatic int elem_count(input int idx);
        if (tbl_op[idx] == 3'b001 || tbl_op[idx] == 3'b100 || tbl_op[idx] == 3'b101) begin
            return int'(tbl_ochan[idx]) * int'(tbl_oside[idx]) * int'(tbl_oside[idx]);
        end
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_descriptor(input int idx);
        check_value("o_op_type", 32'(o_op_type), 32'(tbl_op[idx]));
        check_value("o_padding", 32'(o_padding), 32'(pad_of(idx)));
        check_value("o_stride", 32'(o_stride), 32'(stride_of(idx)));
        check_value("o_kernel", 32'(o_kernel), 32'(kernel_of(idx)));
        check_value("o_i_channel", 32'(o_i_channel), 32'(ichan_of(idx)));
        check_value("o_o_channel", 32'(o_o_channel), 32'(tbl_ochan[idx]));
        check_value("o_i_side", 32'(o_i_side), 32'(iside_of(idx)));
        check_value("o_o_side", 32'(o_o_side), 32'(tbl_oside[idx]));
        check_value("o_weight_addr", o_weight_addr, cmd_word(idx, 3));
        check_value("o_data_addr", o_data_addr, cmd_word(idx, 4));
        check_value("o_result_addr", o_result_addr, tbl_result[idx]);
    endtask

    // Consumer stalls about one cycle in three
    initial begin
        void'($urandom(32'h305a));
        forever begin
            @(posedge clk);
            #1;
            i_wb_ready = ($urandom % 3) != 0;
        end
    end

    // Descriptor check on the sequencer-to-engine handshake
    always @(negedge clk) begin
        if (!rst && u_cnn_ctrl_top.eng_valid && u_cnn_ctrl_top.eng_ready) begin
            assert (issue_idx < run_end) else begin
                $display("Descriptor issued beyond the commands of the run at %0t", $time);
                errors++;
            end
            // Sequencer is mid-run while it offers a command
            check_value("o_busy", 32'(o_busy), 32'd1);
            if (issue_idx < run_end) begin
                compare_descriptor(issue_idx);
            end
            issue_idx++;
            run_issued++;
        end
    end

    // Every taken address must be the next one in the reference stream
    always @(negedge clk) begin
        if (!rst && o_wb_valid && i_wb_ready) begin
            assert (exp_addr.size() != 0) else begin
                $display("Unexpected write-back address 0x%08h at %0t", o_wb_addr, $time);
                errors++;
            end
            if (exp_addr.size() != 0) begin
                check_value("o_wb_addr", o_wb_addr, exp_addr.pop_front());
            end
        end
    end

    task automatic run_commands(input int first, input int num);
        int idx;
        int w;
        int k;
        int tries;
        bit accepted;
        if (timed_out) begin
            return;
        end
        for (idx = first; idx < first + num; idx++) begin
            for (k = 0; k < elem_count(idx); k++) begin
                exp_addr.push_back(tbl_result[idx] + 32'(k));
            end
            sticky_err = sticky_err | tbl_err[idx];
        end
        issue_idx  = first;
        run_end    = first + num;
        run_issued = 0;
        @(posedge clk);
        #1;
        i_cmd_count = cmd_pkg::cmd_cnt_t'(num);
        i_op_en     = 1'b1;
        // Push six words per command and hold each until the FIFO takes it
        for (idx = first; idx < first + num; idx++) begin
            for (w = 0; w < 6; w++) begin
                i_cmd_word  = cmd_word(idx, w);
                i_cmd_valid = 1'b1;
                accepted    = 1'b0;
                tries       = 0;
                while (!accepted && tries < PUSH_LIMIT) begin
                    @(negedge clk);
                    if (o_cmd_ready) begin
                        accepted = 1'b1;
                    end else begin
                        saw_full = 1'b1;
                    end
                    @(posedge clk);
                    #1;
                    tries++;
                end
                if (!accepted) begin
                    $display("Timeout: FIFO never took word %0d of command %0d", w, idx);
                    timeouts++;
                    timed_out   = 1'b1;
                    i_cmd_valid = 1'b0;
                    return;
                end
            end
        end
        i_cmd_valid = 1'b0;
        // Run ends with the interrupt
        tries = 0;
        @(negedge clk);
        while (!o_irq && tries < RUN_LIMIT) begin
            @(negedge clk);
            tries++;
        end
        if (!o_irq) begin
            $display("Timeout: o_irq never rose for the run starting at command %0d", first);
            timeouts++;
            timed_out = 1'b1;
            return;
        end
        // At the first interrupt cycle all work must be done
        check_value("commands issued", 32'(run_issued), 32'(num));
        check_value("pending addresses", 32'(exp_addr.size()), 32'd0);
        check_value("o_busy", 32'(o_busy), 32'd0);
        check_value("o_err", 32'(o_err), 32'(sticky_err));
        @(posedge clk);
        #1;
        i_op_en = 1'b0;
        tries   = 0;
        @(negedge clk);
        while (o_irq && tries < IRQ_CLEAR_LIMIT) begin
            @(negedge clk);
            tries++;
        end
        check_value("o_irq", 32'(o_irq), 32'd0);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        i_op_en     = 1'b0;
        i_cmd_count = '0;
        i_cmd_valid = 1'b0;
        i_cmd_word  = '0;
        i_wb_ready  = 1'b0;
        errors      = 0;
        timeouts    = 0;
        timed_out   = 1'b0;
        saw_full    = 1'b0;
        sticky_err  = 1'b0;
        issue_idx   = 0;
        run_end     = 0;
        run_issued  = 0;
        // Reset outputs are checked before the third rising edge under reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("o_cmd_ready", 32'(o_cmd_ready), 32'd1);
        check_value("o_wb_valid", 32'(o_wb_valid), 32'd0);
        check_value("o_irq", 32'(o_irq), 32'd0);
        check_value("o_busy", 32'(o_busy), 32'd0);
        check_value("o_err", 32'(o_err), 32'd0);
        @(posedge clk);
        #1;
        rst = 1'b0;
        // Large first command keeps the engine busy so the FIFO fills
        run_commands(0, 4);
        if (!timed_out) begin
            assert (saw_full) else begin
                $display("o_cmd_ready never dropped although the FIFO should have filled");
                errors++;
            end
        end
        // Idle and unsupported ops followed by one more stream
        run_commands(4, 3);
        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/cmd_pkg.sv
hdl/ctrl_pkg.sv
hdl/cmd_fifo.sv
hdl/cmd_sequencer.sv
hdl/wb_addr_engine.sv
hdl/cnn_ctrl_top.sv
testbench/tb_cnn_ctrl.sv
